// ==== logic/l1_ctrl_pkg.sv ====
package l1_ctrl_pkg;

	// Cache geometry
	localparam int DCACHE_WAY = 4;
	localparam int DCACHE_SET = 64;
	localparam int LINE_BYTES = 64;
	localparam int INSTR_QUEUE_DEPTH = 2;

	localparam int ADDRESS_BITS = 32;
	localparam int WORD_BITS = 32;
	localparam int OFFSET_BITS = $clog2(LINE_BYTES);
	localparam int SET_BITS = $clog2(DCACHE_SET);
	localparam int TAG_BITS = ADDRESS_BITS - SET_BITS - OFFSET_BITS;
	localparam int WAY_BITS = $clog2(DCACHE_WAY);

	typedef logic [1:0] thread_id_t;
	typedef logic [TAG_BITS-1:0] dcache_tag_t;
	typedef logic [SET_BITS-1:0] dcache_set_t;
	typedef logic [WAY_BITS-1:0] dcache_way_idx_t;
	typedef logic [LINE_BYTES*8/WORD_BITS-1:0][WORD_BITS-1:0] dcache_line_t;
	typedef logic [LINE_BYTES-1:0] dcache_store_mask_t;

	typedef struct packed {
		dcache_tag_t tag;
		dcache_set_t index;
		logic [OFFSET_BITS-1:0] offset;
	} dcache_address_t;

	// Invalid line when both bits are clear
	typedef struct packed {
		logic can_read;
		logic can_write;
	} dcache_privileges_t;

	typedef enum logic {
		CC_UPDATE_INFO_DATA,
		CC_REPLACEMENT
	} cc_command_t;

	// Declaration order is the service priority
	typedef enum logic [2:0] {
		REPLACEMENT,
		FLUSH,
		STORE,
		LOAD,
		INSTR
	} req_kind_t;

	typedef struct packed {
		thread_id_t thread;
		dcache_address_t address;
	} miss_req_t;

	typedef struct packed {
		dcache_address_t address;
		dcache_line_t line;
		dcache_store_mask_t dirty_mask;
	} writeback_req_t;

	typedef struct packed {
		dcache_address_t address;
		dcache_line_t data;
		dcache_store_mask_t dirty_mask;
		logic read;
		logic write;
	} mem_req_t;

	typedef struct packed {
		dcache_way_idx_t way;
		dcache_address_t address;
		dcache_privileges_t privileges;
		dcache_line_t store_value;
		cc_command_t command;
	} ldst_update_t;

endpackage

// ==== logic/instr_miss_queue.sv ====
`timescale 1ns/10ps

module instr_miss_queue (
	input  logic                          clk,
	input  logic                          reset,
	input  logic                          push,
	input  l1_ctrl_pkg::dcache_address_t push_address,
	input  logic                          pop,
	output logic                          empty,
	output l1_ctrl_pkg::dcache_address_t  head_address
);
	import l1_ctrl_pkg::*;

	localparam int PTR_BITS = $clog2(INSTR_QUEUE_DEPTH);

	dcache_address_t entries [INSTR_QUEUE_DEPTH];
	logic [PTR_BITS-1:0] wr_ptr;
	logic [PTR_BITS-1:0] rd_ptr;
	logic [$clog2(INSTR_QUEUE_DEPTH+1)-1:0] level;

	assign empty = level == '0;
	assign head_address = entries[rd_ptr];

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			level <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			// Level holds when both sides move in one cycle
			if (push && !pop)
				level <= level + 1'b1;
			else if (pop && !push)
				level <= level - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (push)
			entries[wr_ptr] <= push_address;
	end

	a_no_overflow: assert property (@(posedge clk) disable iff (reset)
		!(push && !pop && level == INSTR_QUEUE_DEPTH));

endmodule

// ==== logic/snoop_way_match.sv ====
`timescale 1ns/10ps

module snoop_way_match (
	input  logic                                                        clk,
	input  logic                                                        reset,
	input  l1_ctrl_pkg::dcache_tag_t                                    granted_tag,
	input  l1_ctrl_pkg::dcache_tag_t        [l1_ctrl_pkg::DCACHE_WAY-1:0] snoop_tags,
	input  l1_ctrl_pkg::dcache_privileges_t [l1_ctrl_pkg::DCACHE_WAY-1:0] snoop_privileges,
	output logic                                                        snoop_hit,
	output logic                                                        ways_full,
	output l1_ctrl_pkg::dcache_way_idx_t                                matched_way
);
	import l1_ctrl_pkg::*;

	logic [DCACHE_WAY-1:0] way_busy;
	logic [DCACHE_WAY-1:0] way_hit;
	dcache_way_idx_t hit_idx;

	// Scan downwards so the lowest hitting way wins
	always_comb begin
		hit_idx = '0;
		for (int w = DCACHE_WAY - 1; w >= 0; w--) begin
			way_busy[w] = snoop_privileges[w].can_read | snoop_privileges[w].can_write;
			way_hit[w] = way_busy[w] && snoop_tags[w] == granted_tag;
			if (way_hit[w])
				hit_idx = dcache_way_idx_t'(w);
		end
	end

	assign snoop_hit = |way_hit;
	assign ways_full = &way_busy;

	always_ff @(posedge clk, posedge reset) begin
		if (reset)
			matched_way <= '0;
		else if (snoop_hit)
			matched_way <= hit_idx;
	end

endmodule

// ==== logic/victim_way_counter.sv ====
`timescale 1ns/10ps

module victim_way_counter (
	input  logic                         clk,
	input  logic                         reset,
	input  l1_ctrl_pkg::dcache_set_t     set,
	input  logic                         step,
	output l1_ctrl_pkg::dcache_way_idx_t victim_way
);
	import l1_ctrl_pkg::*;

	// One round-robin pointer per set
	dcache_way_idx_t counters [DCACHE_SET];

	assign victim_way = counters[set];

	always_ff @(posedge clk, posedge reset) begin
		if (reset)
			counters <= '{default: '0};
		else if (step)
			counters[set] <= counters[set] + 1'b1;
	end

endmodule

// ==== logic/miss_request_fsm.sv ====
`timescale 1ns/10ps

module miss_request_fsm (
	input  logic                           clk,
	input  logic                           reset,
	input  logic                           load_valid,
	input  logic                           store_valid,
	input  l1_ctrl_pkg::miss_req_t         load_req,
	input  l1_ctrl_pkg::miss_req_t         store_req,
	input  logic                           replacement_valid,
	input  logic                           flush_valid,
	input  l1_ctrl_pkg::writeback_req_t    replacement_req,
	input  l1_ctrl_pkg::writeback_req_t    flush_req,
	input  logic                           instr_pending,
	input  l1_ctrl_pkg::dcache_address_t   instr_address,
	output logic                           dequeue_load,
	output logic                           dequeue_store,
	output logic                           dequeue_replacement,
	output logic                           dequeue_flush,
	output logic                           dequeue_instr,
	output logic                           snoop_tag_valid,
	output l1_ctrl_pkg::dcache_set_t       snoop_set,
	output l1_ctrl_pkg::dcache_address_t   granted_address,
	input  logic                           snoop_hit,
	input  logic                           ways_full,
	input  l1_ctrl_pkg::dcache_way_idx_t   matched_way,
	input  l1_ctrl_pkg::dcache_way_idx_t   victim_way,
	output logic                           victim_step,
	input  logic                           mem_available,
	output logic                           mem_req_valid,
	output l1_ctrl_pkg::mem_req_t          mem_req,
	input  logic                           mem_resp_valid,
	input  l1_ctrl_pkg::dcache_line_t      mem_resp_line,
	output logic                           ldst_update_valid,
	output l1_ctrl_pkg::ldst_update_t      ldst_update,
	output logic                           wakeup,
	output l1_ctrl_pkg::thread_id_t        wakeup_thread,
	output logic                           instr_line_valid,
	output l1_ctrl_pkg::dcache_line_t      instr_line
);
	import l1_ctrl_pkg::*;

	typedef enum logic [1:0] {
		IDLE,
		SEND_REQ,
		WAIT_RESP
	} state_t;

	// need_hit: 1 when the request only proceeds on a snoop hit
	typedef struct packed {
		req_kind_t kind;
		logic read;
		logic write;
		logic need_snoop;
		logic need_hit;
		logic wakeup;
	} grant_t;

	state_t state;
	grant_t pick;
	grant_t grant;
	logic pick_valid;
	thread_id_t pick_thread;
	thread_id_t granted_thread;
	dcache_address_t pick_address;
	dcache_line_t pick_line;
	dcache_line_t granted_line;
	dcache_line_t resp_line;
	dcache_store_mask_t pick_mask;
	dcache_store_mask_t granted_mask;
	dcache_way_idx_t update_way;
	logic snoop_done;
	logic hit_kept;
	logic full_kept;
	logic cur_hit;
	logic cur_full;
	logic execute_req;
	logic issue;
	logic retire;
	logic resp_done;
	logic ldst_kind;

	// Fixed priority pick
	always_comb begin
		pick_valid = 1'b1;
		pick = '0;
		pick_thread = load_req.thread;
		pick_address = load_req.address;
		pick_line = replacement_req.line;
		pick_mask = replacement_req.dirty_mask;
		if (replacement_valid) begin
			pick = '{REPLACEMENT, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0};
			pick_address = replacement_req.address;
		end else if (flush_valid) begin
			pick = '{FLUSH, 1'b0, 1'b1, 1'b1, 1'b1, 1'b0};
			pick_address = flush_req.address;
			pick_line = flush_req.line;
			pick_mask = flush_req.dirty_mask;
		end else if (store_valid) begin
			pick = '{STORE, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1};
			pick_thread = store_req.thread;
			pick_address = store_req.address;
		end else if (load_valid) begin
			pick = '{LOAD, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1};
		end else if (instr_pending) begin
			pick = '{INSTR, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0};
			pick_address = instr_address;
		end else begin
			pick_valid = 1'b0;
		end
	end

	assign snoop_tag_valid = state == IDLE && pick_valid && pick.need_snoop;
	assign snoop_set = pick_address.index;

	// Tags only arrive in the first SEND_REQ cycle, later cycles use the kept result
	assign cur_hit = snoop_done ? hit_kept : snoop_hit;
	assign cur_full = snoop_done ? full_kept : ways_full;
	assign execute_req = !grant.need_snoop || cur_hit == grant.need_hit;

	assign issue = state == SEND_REQ && execute_req && mem_available;
	assign retire = state == SEND_REQ && !execute_req;
	assign resp_done = state == WAIT_RESP && mem_resp_valid;
	assign ldst_kind = grant.kind == LOAD || grant.kind == STORE;

	assign dequeue_replacement = issue && grant.kind == REPLACEMENT;
	assign dequeue_flush = (issue || retire) && grant.kind == FLUSH;
	assign dequeue_store = (retire || resp_done) && grant.kind == STORE;
	assign dequeue_load = (retire || resp_done) && grant.kind == LOAD;
	assign dequeue_instr = resp_done && grant.kind == INSTR;
	assign victim_step = resp_done && ldst_kind;

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			state <= IDLE;
			grant <= '0;
			snoop_done <= 1'b0;
			mem_req_valid <= 1'b0;
			ldst_update_valid <= 1'b0;
			instr_line_valid <= 1'b0;
			wakeup <= 1'b0;
		end else begin
			mem_req_valid <= issue;
			ldst_update_valid <= resp_done && ldst_kind;
			instr_line_valid <= resp_done && grant.kind == INSTR;
			wakeup <= (retire || resp_done) && grant.wakeup;
			case (state)
				IDLE: begin
					snoop_done <= 1'b0;
					if (pick_valid) begin
						grant <= pick;
						state <= SEND_REQ;
					end
				end
				SEND_REQ: begin
					snoop_done <= 1'b1;
					if (retire)
						state <= IDLE;
					else if (issue)
						state <= grant.read ? WAIT_RESP : IDLE;
				end
				WAIT_RESP: begin
					if (mem_resp_valid)
						state <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == IDLE && pick_valid) begin
			granted_thread <= pick_thread;
			granted_address <= pick_address;
			granted_line <= pick_line;
			granted_mask <= pick_mask;
		end
		if (state == SEND_REQ) begin
			hit_kept <= cur_hit;
			full_kept <= cur_full;
		end
		// Counter value before its step picks the victim
		if (resp_done) begin
			resp_line <= mem_resp_line;
			update_way <= victim_way;
		end
	end

	// Granted registers hold until the next grant, so outputs can read them directly
	assign mem_req = '{
		address: granted_address,
		data: granted_line,
		dirty_mask: granted_mask,
		read: grant.read,
		write: grant.write
	};

	assign ldst_update = '{
		way: update_way,
		address: granted_address,
		privileges: '{can_read: 1'b1, can_write: 1'b1},
		store_value: resp_line,
		command: full_kept ? CC_REPLACEMENT : CC_UPDATE_INFO_DATA
	};

	assign wakeup_thread = granted_thread;
	assign instr_line = resp_line;

	a_one_dequeue: assert property (@(posedge clk) disable iff (reset)
		$onehot0({dequeue_load, dequeue_store, dequeue_replacement, dequeue_flush, dequeue_instr}));

	a_mem_req_available: assert property (@(posedge clk) disable iff (reset)
		mem_req_valid |-> $past(mem_available));

	// A flush held by back-pressure keeps the way that its snoop matched
	a_held_way: assert property (@(posedge clk) disable iff (reset)
		(state == SEND_REQ && snoop_done && hit_kept && $past(state == SEND_REQ && snoop_done))
		|-> $stable(matched_way));

endmodule

// ==== logic/l1_cache_controller.sv ====
`timescale 1ns/10ps

module l1_cache_controller (
	input  logic                                                        clk,
	input  logic                                                        reset,
	input  logic                                                        load_valid,
	input  l1_ctrl_pkg::miss_req_t                                      load_req,
	output logic                                                        dequeue_load,
	input  logic                                                        store_valid,
	input  l1_ctrl_pkg::miss_req_t                                      store_req,
	output logic                                                        dequeue_store,
	input  logic                                                        replacement_valid,
	input  l1_ctrl_pkg::writeback_req_t                                 replacement_req,
	output logic                                                        dequeue_replacement,
	input  logic                                                        flush_valid,
	input  l1_ctrl_pkg::writeback_req_t                                 flush_req,
	output logic                                                        dequeue_flush,
	input  logic                                                        instr_miss_valid,
	input  l1_ctrl_pkg::dcache_address_t                                instr_miss_address,
	output logic                                                        instr_available,
	output logic                                                        instr_line_valid,
	output l1_ctrl_pkg::dcache_line_t                                   instr_line,
	output logic                                                        snoop_tag_valid,
	output l1_ctrl_pkg::dcache_set_t                                    snoop_set,
	input  l1_ctrl_pkg::dcache_tag_t        [l1_ctrl_pkg::DCACHE_WAY-1:0] snoop_tags,
	input  l1_ctrl_pkg::dcache_privileges_t [l1_ctrl_pkg::DCACHE_WAY-1:0] snoop_privileges,
	input  logic                                                        mem_available,
	output logic                                                        mem_req_valid,
	output l1_ctrl_pkg::mem_req_t                                       mem_req,
	input  logic                                                        mem_resp_valid,
	input  l1_ctrl_pkg::dcache_line_t                                   mem_resp_line,
	output logic                                                        ldst_update_valid,
	output l1_ctrl_pkg::ldst_update_t                                   ldst_update,
	output logic                                                        wakeup,
	output l1_ctrl_pkg::thread_id_t                                     wakeup_thread
);
	import l1_ctrl_pkg::*;

	logic instr_empty;
	logic dequeue_instr;
	dcache_address_t instr_head;
	dcache_address_t granted_address;
	logic snoop_hit;
	logic ways_full;
	dcache_way_idx_t matched_way;
	dcache_way_idx_t victim_way;
	logic victim_step;

	assign instr_available = instr_empty;

	miss_request_fsm i_fsm (
		.clk                 (clk),
		.reset               (reset),
		.load_valid          (load_valid),
		.store_valid         (store_valid),
		.load_req            (load_req),
		.store_req           (store_req),
		.replacement_valid   (replacement_valid),
		.flush_valid         (flush_valid),
		.replacement_req     (replacement_req),
		.flush_req           (flush_req),
		.instr_pending       (!instr_empty),
		.instr_address       (instr_head),
		.dequeue_load        (dequeue_load),
		.dequeue_store       (dequeue_store),
		.dequeue_replacement (dequeue_replacement),
		.dequeue_flush       (dequeue_flush),
		.dequeue_instr       (dequeue_instr),
		.snoop_tag_valid     (snoop_tag_valid),
		.snoop_set           (snoop_set),
		.granted_address     (granted_address),
		.snoop_hit           (snoop_hit),
		.ways_full           (ways_full),
		.matched_way         (matched_way),
		.victim_way          (victim_way),
		.victim_step         (victim_step),
		.mem_available       (mem_available),
		.mem_req_valid       (mem_req_valid),
		.mem_req             (mem_req),
		.mem_resp_valid      (mem_resp_valid),
		.mem_resp_line       (mem_resp_line),
		.ldst_update_valid   (ldst_update_valid),
		.ldst_update         (ldst_update),
		.wakeup              (wakeup),
		.wakeup_thread       (wakeup_thread),
		.instr_line_valid    (instr_line_valid),
		.instr_line          (instr_line)
	);

	instr_miss_queue i_instr_queue (
		.clk          (clk),
		.reset        (reset),
		.push         (instr_miss_valid),
		.push_address (instr_miss_address),
		.pop          (dequeue_instr),
		.empty        (instr_empty),
		.head_address (instr_head)
	);

	snoop_way_match i_way_match (
		.clk              (clk),
		.reset            (reset),
		.granted_tag      (granted_address.tag),
		.snoop_tags       (snoop_tags),
		.snoop_privileges (snoop_privileges),
		.snoop_hit        (snoop_hit),
		.ways_full        (ways_full),
		.matched_way      (matched_way)
	);

	victim_way_counter i_victim (
		.clk        (clk),
		.reset      (reset),
		.set        (granted_address.index),
		.step       (victim_step),
		.victim_way (victim_way)
	);

endmodule

// ==== tb/tb_l1_cache_controller.sv ====
`timescale 1ns/10ps

module tb_l1_cache_controller;
	import l1_ctrl_pkg::*;

	localparam int MAX_TESTS = 64;
	localparam int CYCLES_PER_TEST = 40;
	localparam int RESET_CYCLES = 16;

	logic clk;
	logic reset;
	logic load_valid;
	miss_req_t load_req;
	logic dequeue_load;
	logic store_valid;
	miss_req_t store_req;
	logic dequeue_store;
	logic replacement_valid;
	writeback_req_t replacement_req;
	logic dequeue_replacement;
	logic flush_valid;
	writeback_req_t flush_req;
	logic dequeue_flush;
	logic instr_miss_valid;
	dcache_address_t instr_miss_address;
	logic instr_available;
	logic instr_line_valid;
	dcache_line_t instr_line;
	logic snoop_tag_valid;
	dcache_set_t snoop_set;
	dcache_tag_t [DCACHE_WAY-1:0] snoop_tags;
	dcache_privileges_t [DCACHE_WAY-1:0] snoop_privileges;
	logic mem_available;
	logic mem_req_valid;
	mem_req_t mem_req;
	logic mem_resp_valid;
	dcache_line_t mem_resp_line;
	logic ldst_update_valid;
	ldst_update_t ldst_update;
	logic wakeup;
	thread_id_t wakeup_thread;

	// Test vectors with one entry per data line
	logic [4:0] tv_kinds [MAX_TESTS];
	dcache_address_t tv_addr [MAX_TESTS];
	thread_id_t tv_thread [MAX_TESTS];
	logic [31:0] tv_line_seed [MAX_TESTS];
	dcache_store_mask_t tv_mask [MAX_TESTS];
	dcache_tag_t [DCACHE_WAY-1:0] tv_tags [MAX_TESTS];
	logic [7:0] tv_privs [MAX_TESTS];
	logic [31:0] tv_resp_seed [MAX_TESTS];
	logic [19:0] tv_exp_mem [MAX_TESTS];
	dcache_way_idx_t tv_exp_way [MAX_TESTS];
	cc_command_t tv_exp_cmd [MAX_TESTS];
	thread_id_t tv_exp_thread [MAX_TESTS];

	dcache_tag_t [DCACHE_WAY-1:0] cur_tags;
	logic [7:0] cur_privs;
	dcache_line_t cur_resp_line;

	int n_tests;
	int error_count;
	int tests_passed;
	int tests_failed;
	int unsigned cycle_count;
	int unsigned cycle_limit;
	int hold_cycles;
	int resp_wait;
	logic [31:0] lfsr_state;

	l1_cache_controller i_dut (.*);

	always #4 clk = ~clk;

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// One LFSR step per bit
	function automatic logic [2:0] draw_3_bits();
		logic [2:0] v;
		v = '0;
		for (int i = 0; i < 3; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			v = {v[1:0], lfsr_state[0]};
		end
		return v;
	endfunction

	function automatic dcache_line_t make_line(input logic [31:0] seed);
		dcache_line_t l;
		for (int i = 0; i < 16; i++)
			l[i] = seed + i * 32'h0100_0193;
		return l;
	endfunction

	// Several kinds in one test get distinct tags in the same set
	function automatic dcache_address_t kind_address(input int t, input req_kind_t k);
		dcache_address_t a;
		a = tv_addr[t];
		if ($countones(tv_kinds[t]) > 1)
			a.tag = a.tag + k;
		return a;
	endfunction

	task automatic report_failure(input string what);
		$display("At %0t: %s", $time, what);
		error_count++;
	endtask

	task automatic check_mem_req(input mem_req_t act, input mem_req_t exp);
		if (act.address !== exp.address || act.read !== exp.read || act.write !== exp.write) begin
			$display("Error at %0t: mem_req address/read/write expected %h/%b/%b got %h/%b/%b",
				$time, exp.address, exp.read, exp.write, act.address, act.read, act.write);
			error_count++;
		end else if (exp.write && (act.data !== exp.data || act.dirty_mask !== exp.dirty_mask)) begin
			$display("Error at %0t: mem_req data/dirty_mask expected %h/%h got %h/%h",
				$time, exp.data, exp.dirty_mask, act.data, act.dirty_mask);
			error_count++;
		end
	endtask

	task automatic check_update(input ldst_update_t act, input ldst_update_t exp);
		if (act !== exp) begin
			$display("Error at %0t: ldst_update way/address/priv/cmd expected %h/%h/%b/%s got %h/%h/%b/%s",
				$time, exp.way, exp.address, exp.privileges, exp.command.name(),
				act.way, act.address, act.privileges, act.command.name());
			$display("Error at %0t: ldst_update.store_value expected %h got %h",
				$time, exp.store_value, act.store_value);
			error_count++;
		end
	endtask

	task automatic check_thread(input thread_id_t act, input thread_id_t exp);
		if (act !== exp) begin
			$display("Error at %0t: wakeup_thread expected %h got %h", $time, exp, act);
			error_count++;
		end
	endtask

	task automatic check_line(input dcache_line_t act, input dcache_line_t exp);
		if (act !== exp) begin
			$display("Error at %0t: instr_line expected %h got %h", $time, exp, act);
			error_count++;
		end
	endtask

	task automatic check_set(input dcache_set_t act, input dcache_set_t exp);
		if (act !== exp) begin
			$display("Error at %0t: snoop_set expected %h got %h", $time, exp, act);
			error_count++;
		end
	endtask

	task automatic read_testdata();
		int fd;
		int n;
		string text;
		logic [31:0] f [15];
		fd = $fopen("tb/l1_ctrl_testdata.txt", "r");
		if (fd == 0) begin
			report_failure("cannot open the test data file");
			return;
		end
		n_tests = 0;
		while (!$feof(fd) && n_tests < MAX_TESTS) begin
			text = "";
			void'($fgets(text, fd));
			if (text.len() < 2 || text[0] == "#")
				continue;
			n = $sscanf(text, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
				f[0], f[1], f[2], f[3], tv_mask[n_tests], f[5], f[6], f[7], f[8],
				f[9], f[10], f[11], f[12], f[13], f[14]);
			if (n != 15) begin
				report_failure("malformed line in the test data file");
				continue;
			end
			tv_kinds[n_tests] = f[0][4:0];
			tv_addr[n_tests] = f[1];
			tv_thread[n_tests] = f[2][1:0];
			tv_line_seed[n_tests] = f[3];
			tv_tags[n_tests] = {f[8][19:0], f[7][19:0], f[6][19:0], f[5][19:0]};
			tv_privs[n_tests] = f[9][7:0];
			tv_resp_seed[n_tests] = f[10];
			tv_exp_mem[n_tests] = f[11][19:0];
			tv_exp_way[n_tests] = f[12][1:0];
			tv_exp_cmd[n_tests] = cc_command_t'(f[13][0]);
			tv_exp_thread[n_tests] = f[14][1:0];
			n_tests++;
		end
		$fclose(fd);
	endtask

	task automatic run_test(input int t);
		req_kind_t exp_kinds[$];
		logic [19:0] ops;
		req_kind_t k;
		mem_req_t exp_req;
		ldst_update_t exp_upd;
		int exp_upds;
		int exp_wakes;
		int mem_seen;
		int upd_seen;
		int wake_seen;
		int instr_seen;
		int iter;
		int settle;
		int errors_at_start;
		errors_at_start = error_count;
		exp_upds = 0;
		ops = tv_exp_mem[t];
		// Expected memory order as kind plus one per nibble from the lowest up
		while (ops[3:0] != 0) begin
			k = req_kind_t'(ops[3:0] - 1);
			exp_kinds.push_back(k);
			if (k == STORE || k == LOAD)
				exp_upds++;
			ops = ops >> 4;
		end
		exp_wakes = tv_kinds[t][STORE] + tv_kinds[t][LOAD];
		mem_seen = 0;
		upd_seen = 0;
		wake_seen = 0;
		instr_seen = 0;
		iter = 0;
		settle = 0;

		@(posedge clk);
		cur_tags <= tv_tags[t];
		cur_privs <= tv_privs[t];
		cur_resp_line <= make_line(tv_resp_seed[t]);
		replacement_valid <= tv_kinds[t][REPLACEMENT];
		replacement_req <= '{kind_address(t, REPLACEMENT), make_line(tv_line_seed[t]), tv_mask[t]};
		flush_valid <= tv_kinds[t][FLUSH];
		flush_req <= '{kind_address(t, FLUSH), make_line(tv_line_seed[t]), tv_mask[t]};
		store_valid <= tv_kinds[t][STORE];
		store_req <= '{tv_thread[t], kind_address(t, STORE)};
		load_valid <= tv_kinds[t][LOAD];
		load_req <= '{tv_thread[t], kind_address(t, LOAD)};
		instr_miss_valid <= tv_kinds[t][INSTR];
		instr_miss_address <= kind_address(t, INSTR);

		while (settle < 4) begin
			@(posedge clk);
			iter++;
			if (iter == 1)
				instr_miss_valid <= 1'b0;
			if (iter == 2 && tv_kinds[t][INSTR] && instr_available)
				report_failure("instr_available is high while an instruction miss is queued");
			if (snoop_tag_valid && tv_kinds[t] == 5'h01)
				report_failure("a replacement caused a snoop");
			if (snoop_tag_valid)
				check_set(snoop_set, tv_addr[t].index);
			if (dequeue_replacement) begin
				if (!mem_available)
					report_failure("replacement dequeued while memory was not available");
				if (!replacement_valid)
					report_failure("replacement dequeued with no replacement pending");
				replacement_valid <= 1'b0;
			end
			if (dequeue_flush) begin
				if (!flush_valid)
					report_failure("flush dequeued with no flush pending");
				flush_valid <= 1'b0;
			end
			if (dequeue_store) begin
				if (!store_valid)
					report_failure("store dequeued with no store pending");
				store_valid <= 1'b0;
			end
			if (dequeue_load) begin
				if (!load_valid)
					report_failure("load dequeued with no load pending");
				load_valid <= 1'b0;
			end
			if (mem_req_valid) begin
				if (mem_seen < exp_kinds.size()) begin
					k = exp_kinds[mem_seen];
					exp_req.address = kind_address(t, k);
					exp_req.data = make_line(tv_line_seed[t]);
					exp_req.dirty_mask = tv_mask[t];
					exp_req.read = k == STORE || k == LOAD || k == INSTR;
					exp_req.write = k == REPLACEMENT || k == FLUSH;
					check_mem_req(mem_req, exp_req);
				end else begin
					report_failure("memory request that was not expected");
				end
				mem_seen++;
			end
			if (ldst_update_valid) begin
				// Store is served before load in the same set
				k = (tv_kinds[t][STORE] && upd_seen == 0 && exp_kinds.size() > 0 &&
					exp_kinds[0] != LOAD) ? STORE : LOAD;
				exp_upd.way = tv_exp_way[t] + upd_seen;
				exp_upd.address = kind_address(t, k);
				exp_upd.privileges = '{can_read: 1'b1, can_write: 1'b1};
				exp_upd.store_value = make_line(tv_resp_seed[t]);
				exp_upd.command = tv_exp_cmd[t];
				check_update(ldst_update, exp_upd);
				upd_seen++;
			end
			if (wakeup) begin
				check_thread(wakeup_thread, tv_exp_thread[t]);
				wake_seen++;
			end
			if (instr_line_valid) begin
				check_line(instr_line, make_line(tv_resp_seed[t]));
				instr_seen++;
			end
			if (!replacement_valid && !flush_valid && !store_valid && !load_valid &&
					mem_seen >= exp_kinds.size() && upd_seen >= exp_upds &&
					wake_seen >= exp_wakes && instr_seen >= tv_kinds[t][INSTR])
				settle++;
		end

		if (mem_seen != exp_kinds.size() || upd_seen != exp_upds || wake_seen != exp_wakes ||
				instr_seen != tv_kinds[t][INSTR])
			report_failure("wrong number of memory requests, updates, wakeups or lines");
		if (!instr_available)
			report_failure("instr_available is low with no instruction miss queued");
		if (error_count == errors_at_start) begin
			tests_passed++;
			$display("Test %0d passed", t);
		end else begin
			tests_failed++;
			$display("Test %0d failed", t);
		end
	endtask

	// Memory model with random busy periods and read latency
	always @(posedge clk, posedge reset) begin
		if (reset) begin
			mem_available <= 1'b0;
			mem_resp_valid <= 1'b0;
			hold_cycles = 0;
			resp_wait = 0;
		end else begin
			mem_resp_valid <= 1'b0;
			if (mem_req_valid) begin
				if (mem_req.read)
					resp_wait = 1 + draw_3_bits();
				hold_cycles = 8 + draw_3_bits();
			end
			if (resp_wait > 0) begin
				resp_wait--;
				if (resp_wait == 0) begin
					mem_resp_valid <= 1'b1;
					mem_resp_line <= cur_resp_line;
				end
			end
			if (hold_cycles > 0) begin
				hold_cycles--;
				mem_available <= 1'b0;
			end else begin
				mem_available <= 1'b1;
			end
		end
	end

	// Tag array answers one cycle after the snoop
	always @(posedge clk) begin
		if (snoop_tag_valid) begin
			snoop_tags <= cur_tags;
			snoop_privileges <= cur_privs;
		end
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
			$display("Timeout after %0d cycles, the controller stopped responding", cycle_count);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		lfsr_state = 32'hc16b8afc;
		cycle_count = 0;
		cycle_limit = 0;
		error_count = 0;
		tests_passed = 0;
		tests_failed = 0;
		n_tests = 0;
		load_valid = 1'b0;
		load_req = '0;
		store_valid = 1'b0;
		store_req = '0;
		replacement_valid = 1'b0;
		replacement_req = '0;
		flush_valid = 1'b0;
		flush_req = '0;
		instr_miss_valid = 1'b0;
		instr_miss_address = '0;
		snoop_tags = '0;
		snoop_privileges = '0;
		mem_available = 1'b0;
		mem_resp_valid = 1'b0;
		mem_resp_line = '0;
		cur_tags = '0;
		cur_privs = '0;
		cur_resp_line = '0;

		read_testdata();
		cycle_limit = RESET_CYCLES + n_tests * CYCLES_PER_TEST;
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;
		for (int t = 0; t < n_tests; t++)
			run_test(t);

		$display("Tests run %0d, passed %0d, failed %0d, errors %0d",
			n_tests, tests_passed, tests_failed, error_count);
		if (error_count == 0 && n_tests > 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

// ==== files.f ====
logic/l1_ctrl_pkg.sv
logic/instr_miss_queue.sv
logic/snoop_way_match.sv
logic/victim_way_counter.sv
logic/miss_request_fsm.sv
logic/l1_cache_controller.sv
tb/tb_l1_cache_controller.sv

// ==== tb/l1_ctrl_testdata.txt ====
# kinds(b0 repl b1 flush b2 store b3 load b4 instr) address thread line_seed dirty_mask tag0..tag3
# privs(2 bits per way) resp_seed exp_mem(kind+1 per nibble, lowest first) exp_way exp_cmd exp_thread
08 12345140 1 a0000000 0000000000000000 00000 00000 00000 00000 00 5eed0001 4 0 0 1
08 22345140 1 a0000000 0000000000000000 12345 00000 00000 00000 03 5eed0002 4 1 0 1
08 52345140 0 a0000000 0000000000000000 12345 22345 32345 42345 ff 5eed0003 4 2 1 0
08 22345140 2 a0000000 0000000000000000 12345 22345 32345 42345 ff 5eed0004 0 0 0 2
04 0000a080 2 a0000000 0000000000000000 00000 00000 00000 00000 00 5eed0005 3 0 0 2
04 0000a080 3 a0000000 0000000000000000 00000 00000 00000 0000a 80 5eed0006 0 0 0 3
02 7777f0c0 0 c0ffee00 00000000ffff0000 00000 7777f 00000 00000 04 5eed0007 2 0 0 0
02 7777f0c0 0 c0ffee00 00000000ffff0000 00000 00000 00000 00000 00 5eed0008 0 0 0 0
01 44440000 0 d00d0000 ffffffffffffffff 00000 00000 00000 00000 00 5eed0009 1 0 0 0
08 62345140 1 a1000000 0000000000000000 12345 22345 32345 42345 ff 5eed000a 4 3 1 1
01 44440fc0 0 d00d1000 0000000000000f0f 00000 00000 00000 00000 00 5eed000b 1 0 0 0
04 0000b080 1 a2000000 0000000000000000 00000 00000 00000 0000a 80 5eed000c 3 1 0 1
01 88880040 0 d00d2000 8000000000000001 00000 00000 00000 00000 00 5eed000d 1 0 0 0
10 00400040 0 00000000 0000000000000000 00000 00000 00000 00000 00 5eed000e 5 0 0 0
10 00400080 0 00000000 0000000000000000 00000 00000 00000 00000 00 5eed000f 5 0 0 0
1f 30000100 3 b0b00000 00000000000000ff 30001 00000 00000 00000 03 5eed0010 54321 0 0 3
08 72345140 2 a3000000 0000000000000000 12345 22345 32345 42345 ff 5eed0011 4 0 1 2
0c 90000200 1 a4000000 0000000000000000 00000 00000 00000 00000 00 5eed0012 43 0 0 1
03 a0000240 0 e0e00000 00ff00ff00ff00ff 00000 00000 a0001 00000 30 5eed0013 21 0 0 0
01 c0000280 0 f0f00000 0000ffff0000ffff 00000 00000 00000 00000 00 5eed0014 1 0 0 0
